// File: source/eu_pkg.sv
package eu_pkg;

  // operand and result datapath
  localparam int DATA_W = 16;

  // operand cache geometry
  localparam int NUM_SLOTS = 8;
  localparam int SLOT_W    = 3; // log2 of NUM_SLOTS

  // lanes offered by the dispatcher per cycle
  localparam int NUM_DISPATCH = 4;

  // in-order instruction queue
  localparam int IQ_DEPTH = 8;
  localparam int IQ_PTR_W = 3; // wraps naturally, IQ_DEPTH is a power of two

  // four units in the fabric
  localparam int EUIDX_W = 2;

  // alu opcodes, all single cycle
  // arithmetic wraps at DATA_W
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1, // a minus b
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_SHL = 3'd5  // a shifted left by b[3:0]
  } eu_opcode_e;

endpackage

// File: source/eu_iqueue.sv
module eu_iqueue #(
  parameter logic [eu_pkg::EUIDX_W-1:0] EU_IDX = '0
) (
  input  logic                        clk,
  input  logic                        rst_i,

  // dispatch lanes
  input  logic                        dispatch_valid_i  [eu_pkg::NUM_DISPATCH-1:0],
  input  eu_pkg::eu_opcode_e          dispatch_opcode_i [eu_pkg::NUM_DISPATCH-1:0],
  input  logic [eu_pkg::SLOT_W-1:0]   dispatch_slot_i   [eu_pkg::NUM_DISPATCH-1:0],
  input  logic [eu_pkg::EUIDX_W-1:0]  dispatch_euidx_i  [eu_pkg::NUM_DISPATCH-1:0],
  output logic                        dispatch_ready_o,

  // head towards alu and cache
  input  logic                        issue_i,
  output logic                        head_valid_o,
  output eu_pkg::eu_opcode_e          head_opcode_o,
  output logic [eu_pkg::SLOT_W-1:0]   head_slot_o
);

  import eu_pkg::*;

  eu_opcode_e          opc_mem  [IQ_DEPTH];
  logic [SLOT_W-1:0]   slot_mem [IQ_DEPTH];

  logic [IQ_PTR_W-1:0] wr_ptr;
  logic [IQ_PTR_W-1:0] rd_ptr;
  logic [IQ_PTR_W:0]   count;     // 0 .. IQ_DEPTH

  logic [NUM_DISPATCH-1:0] lane_match;
  logic [IQ_PTR_W-1:0]     lane_off [NUM_DISPATCH];
  logic [IQ_PTR_W:0]       push_cnt;

  // keep only lanes addressed to this unit
  always_comb begin
    for (int i = 0; i < NUM_DISPATCH; i++) begin
      lane_match[i] = dispatch_valid_i[i] && (dispatch_euidx_i[i] == EU_IDX);
    end
  end

  // compaction: each matching lane gets the next free position
  always_comb begin
    logic [IQ_PTR_W:0] run;
    run = '0;
    for (int i = 0; i < NUM_DISPATCH; i++) begin
      lane_off[i] = run[IQ_PTR_W-1:0];
      if (lane_match[i]) begin
        run = run + (IQ_PTR_W+1)'(1);
      end
    end
    push_cnt = run;
  end

  // entry storage, lane 0 lands first
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_DISPATCH; i++) begin
      if (lane_match[i]) begin
        opc_mem[wr_ptr + lane_off[i]]  <= dispatch_opcode_i[i];
        slot_mem[wr_ptr + lane_off[i]] <= dispatch_slot_i[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + push_cnt[IQ_PTR_W-1:0];
      if (issue_i) begin
        rd_ptr <= rd_ptr + IQ_PTR_W'(1); // one pop per issue
      end
      count <= count + push_cnt - (IQ_PTR_W+1)'(issue_i);
    end
  end

  assign head_valid_o  = (count != '0);
  assign head_opcode_o = opc_mem[rd_ptr];
  assign head_slot_o   = slot_mem[rd_ptr];

  // room for a full dispatch cycle
  assign dispatch_ready_o = (int'(count) <= IQ_DEPTH - NUM_DISPATCH);

  // dispatcher must respect ready, otherwise entries would be overwritten
  a_no_overflow: assert property (@(posedge clk) disable iff (rst_i)
    (push_cnt != '0) |-> (int'(count) + int'(push_cnt) <= IQ_DEPTH));

  // the alu may only pop an existing head
  a_issue_needs_head: assert property (@(posedge clk) disable iff (rst_i)
    issue_i |-> head_valid_o);

endmodule

// File: source/eu_operand_cache.sv
module eu_operand_cache (
  input  logic                       clk,
  input  logic                       rst_i,

  // interconnect write port 0, operand a
  input  logic                       icon_rx0_valid_i,
  input  logic [eu_pkg::SLOT_W-1:0]  icon_rx0_slot_i,
  input  logic [eu_pkg::DATA_W-1:0]  icon_rx0_data_i,
  output logic                       icon_rx0_accept_o,

  // interconnect write port 1, operand b
  input  logic                       icon_rx1_valid_i,
  input  logic [eu_pkg::SLOT_W-1:0]  icon_rx1_slot_i,
  input  logic [eu_pkg::DATA_W-1:0]  icon_rx1_data_i,
  output logic                       icon_rx1_accept_o,

  // interconnect result read port
  input  logic                       icon_tx_req_valid_i,
  input  logic [eu_pkg::SLOT_W-1:0]  icon_tx_addr_i,
  output logic [eu_pkg::DATA_W-1:0]  icon_tx_data_o,
  output logic                       icon_tx_success_o,

  // head instruction lookup
  input  logic [eu_pkg::SLOT_W-1:0]  head_slot_i,
  input  logic                       issue_i,
  output logic                       opnd_ready_o,
  output logic [eu_pkg::DATA_W-1:0]  opnd_a_o,
  output logic [eu_pkg::DATA_W-1:0]  opnd_b_o,

  // alu writeback
  input  logic                       res_valid_i,
  input  logic [eu_pkg::SLOT_W-1:0]  res_slot_i,
  input  logic [eu_pkg::DATA_W-1:0]  res_data_i
);

  import eu_pkg::*;

  logic [DATA_W-1:0] a_mem [NUM_SLOTS];
  logic [DATA_W-1:0] b_mem [NUM_SLOTS];
  logic [DATA_W-1:0] r_mem [NUM_SLOTS];

  // present bits per slot
  logic [NUM_SLOTS-1:0] a_vld;
  logic [NUM_SLOTS-1:0] b_vld;
  logic [NUM_SLOTS-1:0] r_vld;

  logic a_busy; // operand a of the rx0 slot still held
  logic b_busy;

  // an issue this cycle frees the head slot before the write is judged
  always_comb begin
    a_busy = a_vld[icon_rx0_slot_i] && !(issue_i && (head_slot_i == icon_rx0_slot_i));
    b_busy = b_vld[icon_rx1_slot_i] && !(issue_i && (head_slot_i == icon_rx1_slot_i));
  end

  assign icon_rx0_accept_o = icon_rx0_valid_i && !a_busy;
  assign icon_rx1_accept_o = icon_rx1_valid_i && !b_busy;

  // head operand lookup
  assign opnd_ready_o = a_vld[head_slot_i] && b_vld[head_slot_i];
  assign opnd_a_o     = a_mem[head_slot_i];
  assign opnd_b_o     = b_mem[head_slot_i];

  // present-bit bookkeeping
  always_ff @(posedge clk) begin
    if (rst_i) begin
      a_vld <= '0;
      b_vld <= '0;
      r_vld <= '0;
    end else begin
      if (issue_i) begin
        a_vld[head_slot_i] <= 1'b0;
        b_vld[head_slot_i] <= 1'b0;
      end
      // new operands make the old result stale
      if (icon_rx0_accept_o) begin
        a_vld[icon_rx0_slot_i] <= 1'b1;
        r_vld[icon_rx0_slot_i] <= 1'b0;
      end
      if (icon_rx1_accept_o) begin
        b_vld[icon_rx1_slot_i] <= 1'b1;
        r_vld[icon_rx1_slot_i] <= 1'b0;
      end
      // a landing result belongs to an earlier issue and takes priority
      if (res_valid_i) begin
        r_vld[res_slot_i] <= 1'b1;
      end
    end
  end

  // slot payload and read data
  always_ff @(posedge clk) begin
    if (icon_rx0_accept_o) a_mem[icon_rx0_slot_i] <= icon_rx0_data_i;
    if (icon_rx1_accept_o) b_mem[icon_rx1_slot_i] <= icon_rx1_data_i;
    if (res_valid_i)       r_mem[res_slot_i]      <= res_data_i;
    icon_tx_data_o <= r_mem[icon_tx_addr_i];
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      icon_tx_success_o <= 1'b0;
    end else begin
      icon_tx_success_o <= icon_tx_req_valid_i && r_vld[icon_tx_addr_i];
    end
  end

  // writeback and a fresh issue never meet on one slot
  a_res_vs_issue: assert property (@(posedge clk) disable iff (rst_i)
    (res_valid_i && issue_i) |-> (res_slot_i != head_slot_i));

endmodule

// File: source/eu_alu.sv
module eu_alu (
  input  logic                       clk,
  input  logic                       rst_i,

  // head of the instruction queue
  input  logic                       head_valid_i,
  input  eu_pkg::eu_opcode_e         head_opcode_i,
  input  logic [eu_pkg::SLOT_W-1:0]  head_slot_i,

  // operands of the head slot
  input  logic                       opnd_ready_i,
  input  logic [eu_pkg::DATA_W-1:0]  opnd_a_i,
  input  logic [eu_pkg::DATA_W-1:0]  opnd_b_i,

  output logic                       issue_o,

  // writeback to the cache
  output logic                       res_valid_o,
  output logic [eu_pkg::SLOT_W-1:0]  res_slot_o,
  output logic [eu_pkg::DATA_W-1:0]  res_data_o
);

  import eu_pkg::*;

  logic [DATA_W-1:0] alu_res;

  // the only issue decision in the unit
  assign issue_o = head_valid_i && opnd_ready_i;

  always_comb begin
    case (head_opcode_i)
      OP_ADD:  alu_res = opnd_a_i + opnd_b_i;
      OP_SUB:  alu_res = opnd_a_i - opnd_b_i;
      OP_AND:  alu_res = opnd_a_i & opnd_b_i;
      OP_OR:   alu_res = opnd_a_i | opnd_b_i;
      OP_XOR:  alu_res = opnd_a_i ^ opnd_b_i;
      OP_SHL:  alu_res = opnd_a_i << opnd_b_i[3:0]; // shift amount 0..15
      default: alu_res = '0;
    endcase
  end

  // one-cycle valid strobe
  always_ff @(posedge clk) begin
    if (rst_i) begin
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= issue_o;
    end
  end

  // result and target slot captured on issue
  always_ff @(posedge clk) begin
    if (issue_o) begin
      res_slot_o <= head_slot_i;
      res_data_o <= alu_res;
    end
  end

  // queue entries only ever carry decoded opcodes from the dispatcher
  a_known_opcode: assert property (@(posedge clk) disable iff (rst_i)
    issue_o |-> (head_opcode_i inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL}));

endmodule

// File: source/execution_unit.sv
module execution_unit #(
  parameter logic [eu_pkg::EUIDX_W-1:0] EU_IDX = '0
) (
  input  logic                        clk,
  input  logic                        rst_i,

  // dispatcher
  input  logic                        dispatch_valid_i  [eu_pkg::NUM_DISPATCH-1:0],
  input  eu_pkg::eu_opcode_e          dispatch_opcode_i [eu_pkg::NUM_DISPATCH-1:0],
  input  logic [eu_pkg::SLOT_W-1:0]   dispatch_slot_i   [eu_pkg::NUM_DISPATCH-1:0],
  input  logic [eu_pkg::EUIDX_W-1:0]  dispatch_euidx_i  [eu_pkg::NUM_DISPATCH-1:0],
  output logic                        dispatch_ready_o, // stall dispatch when low

  // interconnect operand writes
  input  logic                        icon_rx0_valid_i,
  input  logic [eu_pkg::SLOT_W-1:0]   icon_rx0_slot_i,
  input  logic [eu_pkg::DATA_W-1:0]   icon_rx0_data_i,
  output logic                        icon_rx0_accept_o,
  input  logic                        icon_rx1_valid_i,
  input  logic [eu_pkg::SLOT_W-1:0]   icon_rx1_slot_i,
  input  logic [eu_pkg::DATA_W-1:0]   icon_rx1_data_i,
  output logic                        icon_rx1_accept_o,

  // interconnect result read
  input  logic                        icon_tx_req_valid_i,
  input  logic [eu_pkg::SLOT_W-1:0]   icon_tx_addr_i,
  output logic [eu_pkg::DATA_W-1:0]   icon_tx_data_o,
  output logic                        icon_tx_success_o
);

  import eu_pkg::*;

  // queue head
  logic              head_valid;
  eu_opcode_e        head_opcode;
  logic [SLOT_W-1:0] head_slot;

  // operand lookup and issue
  logic              opnd_ready;
  logic [DATA_W-1:0] opnd_a;
  logic [DATA_W-1:0] opnd_b;
  logic              issue;

  // writeback
  logic              res_valid;
  logic [SLOT_W-1:0] res_slot;
  logic [DATA_W-1:0] res_data;

  eu_iqueue #(
    .EU_IDX (EU_IDX)
  ) iqueue_inst (
    .clk               (clk),
    .rst_i             (rst_i),
    .dispatch_valid_i  (dispatch_valid_i),
    .dispatch_opcode_i (dispatch_opcode_i),
    .dispatch_slot_i   (dispatch_slot_i),
    .dispatch_euidx_i  (dispatch_euidx_i),
    .dispatch_ready_o  (dispatch_ready_o),
    .issue_i           (issue),
    .head_valid_o      (head_valid),
    .head_opcode_o     (head_opcode),
    .head_slot_o       (head_slot)
  );

  eu_operand_cache cache_inst (
    .clk                 (clk),
    .rst_i               (rst_i),
    .icon_rx0_valid_i    (icon_rx0_valid_i),
    .icon_rx0_slot_i     (icon_rx0_slot_i),
    .icon_rx0_data_i     (icon_rx0_data_i),
    .icon_rx0_accept_o   (icon_rx0_accept_o),
    .icon_rx1_valid_i    (icon_rx1_valid_i),
    .icon_rx1_slot_i     (icon_rx1_slot_i),
    .icon_rx1_data_i     (icon_rx1_data_i),
    .icon_rx1_accept_o   (icon_rx1_accept_o),
    .icon_tx_req_valid_i (icon_tx_req_valid_i),
    .icon_tx_addr_i      (icon_tx_addr_i),
    .icon_tx_data_o      (icon_tx_data_o),
    .icon_tx_success_o   (icon_tx_success_o),
    .head_slot_i         (head_slot),
    .issue_i             (issue),
    .opnd_ready_o        (opnd_ready),
    .opnd_a_o            (opnd_a),
    .opnd_b_o            (opnd_b),
    .res_valid_i         (res_valid),
    .res_slot_i          (res_slot),
    .res_data_i          (res_data)
  );

  eu_alu alu_inst (
    .clk           (clk),
    .rst_i         (rst_i),
    .head_valid_i  (head_valid),
    .head_opcode_i (head_opcode),
    .head_slot_i   (head_slot),
    .opnd_ready_i  (opnd_ready),
    .opnd_a_i      (opnd_a),
    .opnd_b_i      (opnd_b),
    .issue_o       (issue),
    .res_valid_o   (res_valid),
    .res_slot_o    (res_slot),
    .res_data_o    (res_data)
  );

endmodule

// File: testbench/tb_execution_unit.sv
module tb_execution_unit;

  timeunit 1ns;
  timeprecision 1ps;

  import eu_pkg::*;

  localparam logic [EUIDX_W-1:0] MY_IDX = 2'd1;
  localparam int TIMEOUT_CYCLES = 4000;

  logic clk;
  logic rst_i;

  // index ranges match the dut ports so lane 0 lines up
  logic               dispatch_valid  [NUM_DISPATCH-1:0];
  eu_opcode_e         dispatch_opcode [NUM_DISPATCH-1:0];
  logic [SLOT_W-1:0]  dispatch_slot   [NUM_DISPATCH-1:0];
  logic [EUIDX_W-1:0] dispatch_euidx  [NUM_DISPATCH-1:0];
  logic               dispatch_ready;

  logic              rx0_valid;
  logic [SLOT_W-1:0] rx0_slot;
  logic [DATA_W-1:0] rx0_data;
  logic              rx0_accept;
  logic              rx1_valid;
  logic [SLOT_W-1:0] rx1_slot;
  logic [DATA_W-1:0] rx1_data;
  logic              rx1_accept;

  logic              tx_req_valid;
  logic [SLOT_W-1:0] tx_addr;
  logic [DATA_W-1:0] tx_data;
  logic              tx_success;

  // reference slot table
  logic [DATA_W-1:0] model_a      [NUM_SLOTS];
  logic [DATA_W-1:0] model_b      [NUM_SLOTS];
  logic              model_a_have [NUM_SLOTS];
  logic              model_b_have [NUM_SLOTS];
  eu_opcode_e        model_op     [NUM_SLOTS];

  int cycle_cnt = 0;

  execution_unit #(
    .EU_IDX (MY_IDX)
  ) execution_unit_inst (
    .clk                 (clk),
    .rst_i               (rst_i),
    .dispatch_valid_i    (dispatch_valid),
    .dispatch_opcode_i   (dispatch_opcode),
    .dispatch_slot_i     (dispatch_slot),
    .dispatch_euidx_i    (dispatch_euidx),
    .dispatch_ready_o    (dispatch_ready),
    .icon_rx0_valid_i    (rx0_valid),
    .icon_rx0_slot_i     (rx0_slot),
    .icon_rx0_data_i     (rx0_data),
    .icon_rx0_accept_o   (rx0_accept),
    .icon_rx1_valid_i    (rx1_valid),
    .icon_rx1_slot_i     (rx1_slot),
    .icon_rx1_data_i     (rx1_data),
    .icon_rx1_accept_o   (rx1_accept),
    .icon_tx_req_valid_i (tx_req_valid),
    .icon_tx_addr_i      (tx_addr),
    .icon_tx_data_o      (tx_data),
    .icon_tx_success_o   (tx_success)
  );

  always #4 clk = ~clk; // 8 ns period

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: no end of test after %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
      input logic [DATA_W-1:0] act);
    assert (act === exp) else begin
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    assert (act === exp) else begin
      $display("mismatch %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  // a read without request never reports success
  a_idle_read: assert property (@(posedge clk) disable iff (rst_i)
    !tx_req_valid |=> !tx_success)
    else begin
      $display("mismatch idle read: expected 0, actual 1");
      abort_run();
    end

  a_reset_state: assert property (@(posedge clk) $fell(rst_i) |-> (dispatch_ready && !tx_success))
    else begin
      $display("unit is not idle and ready right after reset");
      abort_run();
    end

  // opcode table, arithmetic wraps at 16 bits
  function automatic logic [DATA_W-1:0] expected_result(input eu_opcode_e op,
      input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SHL:  return a << b[3:0];
      default: return '0;
    endcase
  endfunction

  function automatic eu_opcode_e random_opcode();
    logic [2:0] code;
    code = 3'($urandom_range(5, 0));
    return eu_opcode_e'(code);
  endfunction

  function automatic logic [EUIDX_W-1:0] foreign_idx();
    logic [EUIDX_W-1:0] idx;
    idx = EUIDX_W'($urandom_range(3, 0));
    if (idx == MY_IDX) begin
      idx = 2'd3;
    end
    return idx;
  endfunction

  // all tasks start and end right after a falling edge
  task automatic write_operands(input string name, input logic [SLOT_W-1:0] slot,
      input logic do_a, input logic do_b,
      input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
    logic exp_a;
    logic exp_b;
    exp_a = do_a && !model_a_have[slot]; // refused while still present
    exp_b = do_b && !model_b_have[slot];
    rx0_valid = do_a;
    rx0_slot  = slot;
    rx0_data  = a;
    rx1_valid = do_b;
    rx1_slot  = slot;
    rx1_data  = b;
    #2;
    check_bit({name, " accept a"}, exp_a, rx0_accept);
    check_bit({name, " accept b"}, exp_b, rx1_accept);
    if (exp_a) begin
      model_a[slot]      = a;
      model_a_have[slot] = 1'b1;
    end
    if (exp_b) begin
      model_b[slot]      = b;
      model_b_have[slot] = 1'b1;
    end
    @(negedge clk);
    rx0_valid = 1'b0;
    rx1_valid = 1'b0;
  endtask

  task automatic set_lane(input int lane, input logic [EUIDX_W-1:0] idx,
      input eu_opcode_e op, input logic [SLOT_W-1:0] slot);
    dispatch_valid[lane]  = 1'b1;
    dispatch_euidx[lane]  = idx;
    dispatch_opcode[lane] = op;
    dispatch_slot[lane]   = slot;
    if (idx == MY_IDX) begin
      model_op[slot] = op; // this unit will run it
    end
  endtask

  task automatic send_dispatch(input string name);
    check_bit({name, " ready"}, 1'b1, dispatch_ready);
    @(negedge clk);
    for (int i = 0; i < NUM_DISPATCH; i++) begin
      dispatch_valid[i] = 1'b0;
    end
  endtask

  task automatic read_slot(input logic [SLOT_W-1:0] slot, output logic ok,
      output logic [DATA_W-1:0] data);
    tx_req_valid = 1'b1;
    tx_addr      = slot;
    @(negedge clk);
    tx_req_valid = 1'b0;
    ok   = tx_success; // registered, stable by now
    data = tx_data;
  endtask

  task automatic expect_no_result(input string name, input logic [SLOT_W-1:0] slot);
    logic              ok;
    logic [DATA_W-1:0] data;
    read_slot(slot, ok, data);
    check_bit(name, 1'b0, ok);
  endtask

  task automatic wait_result(input string name, input logic [SLOT_W-1:0] slot);
    logic              ok;
    logic [DATA_W-1:0] data;
    ok = 1'b0;
    while (!ok) begin
      read_slot(slot, ok, data);
    end
    check_data(name, expected_result(model_op[slot], model_a[slot], model_b[slot]), data);
    model_a_have[slot] = 1'b0; // consumed by the issue
    model_b_have[slot] = 1'b0;
  endtask

  initial begin
    logic [SLOT_W-1:0] bp_slots [4] = '{3'd0, 3'd1, 3'd2, 3'd5};
    void'($urandom(32'h0dae_ad37));
    clk          = 1'b0;
    rst_i        = 1'b1;
    rx0_valid    = 1'b0;
    rx0_slot     = '0;
    rx0_data     = '0;
    rx1_valid    = 1'b0;
    rx1_slot     = '0;
    rx1_data     = '0;
    tx_req_valid = 1'b0;
    tx_addr      = '0;
    for (int i = 0; i < NUM_DISPATCH; i++) begin
      dispatch_valid[i]  = 1'b0;
      dispatch_opcode[i] = OP_ADD;
      dispatch_slot[i]   = '0;
      dispatch_euidx[i]  = '0;
    end
    for (int i = 0; i < NUM_SLOTS; i++) begin
      model_a_have[i] = 1'b0;
      model_b_have[i] = 1'b0;
      model_op[i]     = OP_ADD;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;

    // every opcode once, slot k for opcode k
    for (int k = 0; k < 6; k++) begin
      write_operands("opcode operands", SLOT_W'(k), 1'b1, 1'b1, 16'($urandom), 16'($urandom));
      set_lane(int'($urandom_range(3, 0)), MY_IDX, eu_opcode_e'(3'(k)), SLOT_W'(k));
      send_dispatch("opcode dispatch");
      wait_result("opcode result", SLOT_W'(k));
    end

    // foreign lanes mixed in, lane 0 blocks lane 2
    write_operands("foreign operands", 3'd7, 1'b1, 1'b1, 16'($urandom), 16'($urandom));
    write_operands("lane 2 operands", 3'd2, 1'b1, 1'b1, 16'($urandom), 16'($urandom));
    set_lane(0, MY_IDX, random_opcode(), 3'd1);
    set_lane(1, foreign_idx(), random_opcode(), 3'd7);
    set_lane(2, MY_IDX, random_opcode(), 3'd2);
    set_lane(3, foreign_idx(), random_opcode(), 3'd7);
    send_dispatch("filter dispatch");
    repeat (5) expect_no_result("lane 2 ahead of lane 0", 3'd2);
    write_operands("lane 0 operands", 3'd1, 1'b1, 1'b1, 16'($urandom), 16'($urandom));
    wait_result("lane 0 result", 3'd1);
    wait_result("lane 2 result", 3'd2);
    repeat (50) @(negedge clk);
    expect_no_result("foreign lanes only", 3'd7);

    // second write refused, first values used
    write_operands("first write", 3'd3, 1'b1, 1'b1, 16'($urandom), 16'($urandom));
    write_operands("second write", 3'd3, 1'b1, 1'b1, 16'($urandom), 16'($urandom));
    set_lane(int'($urandom_range(3, 0)), MY_IDX, random_opcode(), 3'd3);
    send_dispatch("overwrite dispatch");
    wait_result("overwrite result", 3'd3);
    write_operands("write after issue", 3'd3, 1'b1, 1'b1, 16'($urandom), 16'($urandom));

    // dispatched before its operands
    set_lane(3, MY_IDX, random_opcode(), 3'd6);
    send_dispatch("early dispatch");
    repeat (3) expect_no_result("no operands yet", 3'd6);
    write_operands("operand a only", 3'd6, 1'b1, 1'b0, 16'($urandom), 16'h0);
    repeat (3) expect_no_result("operand b missing", 3'd6);
    write_operands("operand b late", 3'd6, 1'b0, 1'b1, 16'h0, 16'($urandom));
    wait_result("late operand result", 3'd6);

    // blocked head, five entries queued
    foreach (bp_slots[k]) begin
      write_operands("queued operands", bp_slots[k], 1'b1, 1'b1, 16'($urandom), 16'($urandom));
    end
    set_lane(0, MY_IDX, random_opcode(), 3'd4);
    set_lane(1, MY_IDX, random_opcode(), bp_slots[0]);
    set_lane(2, MY_IDX, random_opcode(), bp_slots[1]);
    set_lane(3, MY_IDX, random_opcode(), bp_slots[2]);
    send_dispatch("fill dispatch");
    set_lane(int'($urandom_range(3, 0)), MY_IDX, random_opcode(), bp_slots[3]);
    send_dispatch("fifth entry dispatch");
    check_bit("ready with five queued", 1'b0, dispatch_ready);
    write_operands("head operands", 3'd4, 1'b1, 1'b1, 16'($urandom), 16'($urandom));
    wait_result("blocked head result", 3'd4);
    foreach (bp_slots[k]) begin
      wait_result("drained result", bp_slots[k]);
    end
    check_bit("ready after drain", 1'b1, dispatch_ready);

    // empty, stale and unrequested reads
    expect_no_result("never issued slot", 3'd7);
    expect_no_result("stale result", 3'd3);
    tx_addr      = 3'd6;
    tx_req_valid = 1'b0;
    @(negedge clk);
    check_bit("read without request", 1'b0, tx_success);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: files.f
source/eu_pkg.sv
source/eu_iqueue.sv
source/eu_operand_cache.sv
source/eu_alu.sv
source/execution_unit.sv
testbench/tb_execution_unit.sv

// File: Makefile
all: run

obj_dir/Vtb_execution_unit: files.f $(wildcard source/*.sv) $(wildcard testbench/*.sv)
	verilator --binary --timing --assert -f files.f --top-module tb_execution_unit

run: obj_dir/Vtb_execution_unit
	@out="$$(./obj_dir/Vtb_execution_unit)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

.PHONY: all run clean
